//--- hdmi_backend.f
hdmi_pkg.sv
video_if.sv
hdmi_timebase.sv
hdmi_pixel_source.sv
hdmi_tdms_enc.sv
hdmi_backend.sv
hdmi_backend_chk.sv
tb_hdmi_backend.sv

//--- hdmi_backend.sv
/*
 * HDMI back end, pixel clock domain
 * Timebase, pixel source and three TMDS encoders, with the
 * screen position brought out for external pixel logic
 */

`timescale 1ns/10ps

module hdmi_backend #(
    parameter hdmi_pkg::bus11_t h_screen     = 11'd32,
    parameter hdmi_pkg::bus11_t h_frame      = 11'd44,
    parameter hdmi_pkg::bus11_t h_sync_start = 11'd35,
    parameter hdmi_pkg::bus11_t h_sync_end   = 11'd39,
    parameter hdmi_pkg::bus11_t v_screen     = 11'd8,
    parameter hdmi_pkg::bus11_t v_frame      = 11'd12,
    parameter hdmi_pkg::bus11_t v_sync_start = 11'd9,
    parameter hdmi_pkg::bus11_t v_sync_end   = 11'd10
) (
    input  logic               clk_pix,
    input  logic               reset,
    input  hdmi_pkg::pattern_t mode,
    // External pixel, sampled two clocks ahead of its symbols
    input  hdmi_pkg::pix_t     pix,
    // Current scan position
    output hdmi_pkg::bus11_t   hcount,
    output hdmi_pkg::bus11_t   vcount,
    output hdmi_pkg::symbol_t  tmds_red,
    output hdmi_pkg::symbol_t  tmds_green,
    output hdmi_pkg::symbol_t  tmds_blue
);
    import hdmi_pkg::*;

    // Red and green carry no control information
    localparam ctrl_t CTRL_IDLE = 2'b00;

    video_if vid_a ();
    video_if vid_b ();

    ctrl_t ctrl_blue;

    // ------------------------------
    // Timebase and pixel source
    // ------------------------------
    hdmi_timebase #(
        .h_screen     (h_screen),
        .h_frame      (h_frame),
        .h_sync_start (h_sync_start),
        .h_sync_end   (h_sync_end),
        .v_screen     (v_screen),
        .v_frame      (v_frame),
        .v_sync_start (v_sync_start),
        .v_sync_end   (v_sync_end)
    ) u_timebase (
        .clk_pix (clk_pix),
        .reset   (reset),
        .vid     (vid_a.source)
    );

    hdmi_pixel_source #(
        .h_screen (h_screen)
    ) u_pixel_source (
        .clk_pix (clk_pix),
        .reset   (reset),
        .mode    (mode),
        .pix     (pix),
        .vid_in  (vid_a.sink),
        .vid_out (vid_b.source)
    );

    // Position leaves from stage A, external logic answers with pix
    assign hcount = vid_a.hcount;
    assign vcount = vid_a.vcount;

    // ------------------------------
    // TMDS channels
    // ------------------------------
    // Syncs ride on the blue channel
    assign ctrl_blue = {vid_b.vsync, vid_b.hsync};

    hdmi_tdms_enc u_tmds_red (
        .clk_pix (clk_pix),
        .reset   (reset),
        .blank   (vid_b.blank),
        .ctrl    (CTRL_IDLE),
        .data    (vid_b.pix[23:16]),
        .encoded (tmds_red)
    );

    hdmi_tdms_enc u_tmds_green (
        .clk_pix (clk_pix),
        .reset   (reset),
        .blank   (vid_b.blank),
        .ctrl    (CTRL_IDLE),
        .data    (vid_b.pix[15:8]),
        .encoded (tmds_green)
    );

    hdmi_tdms_enc u_tmds_blue (
        .clk_pix (clk_pix),
        .reset   (reset),
        .blank   (vid_b.blank),
        .ctrl    (ctrl_blue),
        .data    (vid_b.pix[7:0]),
        .encoded (tmds_blue)
    );

endmodule: hdmi_backend

//--- hdmi_backend_chk.sv
/*
 * HDMI back end checker
 * Keeps a two-cycle history of the scan, decodes the TMDS symbols
 * and checks counters, blanking, pixels and DC balance
 */

`timescale 1ns/10ps

module hdmi_backend_chk #(
    parameter hdmi_pkg::bus11_t h_screen     = 11'd32,
    parameter hdmi_pkg::bus11_t h_frame      = 11'd44,
    parameter hdmi_pkg::bus11_t h_sync_start = 11'd35,
    parameter hdmi_pkg::bus11_t h_sync_end   = 11'd39,
    parameter hdmi_pkg::bus11_t v_screen     = 11'd8,
    parameter hdmi_pkg::bus11_t v_frame      = 11'd12,
    parameter hdmi_pkg::bus11_t v_sync_start = 11'd9,
    parameter hdmi_pkg::bus11_t v_sync_end   = 11'd10
) (
    input logic               clk_pix,
    input logic               reset,
    input hdmi_pkg::pattern_t mode,
    input hdmi_pkg::pix_t     pix,
    input hdmi_pkg::bus11_t   hcount,
    input hdmi_pkg::bus11_t   vcount,
    input hdmi_pkg::symbol_t  tmds_red,
    input hdmi_pkg::symbol_t  tmds_green,
    input hdmi_pkg::symbol_t  tmds_blue
);
    import hdmi_pkg::*;

    // Failed assertions, read by the testbench
    int                err_count = 0;

    // Cycles since reset release, saturating at 3
    logic [1:0]        run_cycles;
    logic              checking;

    // History, index 1 is one cycle back, index 2 two cycles back
    bus11_t            h1;
    bus11_t            h2;
    bus11_t            v1;
    bus11_t            v2;
    pattern_t          mode1;
    pattern_t          mode2;
    pix_t              pix1;
    pix_t              pix2;

    // Expected scan and output
    bus11_t            h_exp;
    bus11_t            v_exp;
    logic              vis2;
    logic              hs2;
    logic              vs2;
    int                bar;
    bus11_t            ramp_sum;
    pix_t              pix_exp;
    symbol_t           blue_exp;

    // Per channel, 0 red, 1 green, 2 blue
    symbol_t           sym [3];
    color_t            dec [3];
    logic signed [6:0] rd [3];
    logic signed [6:0] rd_now [3];
    logic [2:0]        bal_ok;
    logic [2:0]        flag_ok;

    // ------------------------------
    // TMDS decode rules
    // ------------------------------
    function automatic color_t tmds_decode(symbol_t code);
        logic [7:0] d;
        color_t     c;
        // Bit 9 undoes the inversion, bit 8 selects XOR or XNOR
        d = code[9] ? ~code[7:0] : code[7:0];
        c[0] = d[0];
        for (int i = 1; i < 8; i++) begin
            c[i] = code[8] ? (d[i] ^ d[i-1]) : ~(d[i] ^ d[i-1]);
        end
        return c;
    endfunction

    // Ones minus zeros over all ten bits of a symbol
    function automatic logic signed [6:0] sym_balance(symbol_t code);
        logic signed [6:0] b;
        b = -7'sd10;
        for (int i = 0; i < 10; i++) begin
            if (code[i]) begin
                b = b + 7'sd2;
            end
        end
        return b;
    endfunction

    // XOR flag must follow the ones count of the decoded byte
    function automatic logic flag_matches(symbol_t code);
        color_t     c;
        logic [3:0] ones;
        c = tmds_decode(code);
        ones = '0;
        for (int i = 0; i < 8; i++) begin
            ones = ones + 4'(c[i]);
        end
        return code[8] == !((ones > 4'd4) || ((ones == 4'd4) && !c[0]));
    endfunction

    // ------------------------------
    // Expected values
    // ------------------------------
    always_comb begin
        checking = (run_cycles >= 2'd2);

        // Next scan position from the previous one
        h_exp = h1 + 11'd1;
        v_exp = v1;
        if (h1 == h_frame - 11'd1) begin
            h_exp = '0;
            v_exp = (v1 == v_frame - 11'd1) ? '0 : v1 + 11'd1;
        end

        vis2 = (h2 < h_screen) && (v2 < v_screen);
        hs2  = ((h2 >= h_sync_start) && (h2 < h_sync_end)) ? HSYNC_POLARITY : ~HSYNC_POLARITY;
        vs2  = ((v2 >= v_sync_start) && (v2 < v_sync_end)) ? VSYNC_POLARITY : ~VSYNC_POLARITY;

        case ({vs2, hs2})
            2'b00:   blue_exp = TMDS_CTRL_00;
            2'b01:   blue_exp = TMDS_CTRL_01;
            2'b10:   blue_exp = TMDS_CTRL_10;
            default: blue_exp = TMDS_CTRL_11;
        endcase

        // Bar index over eight equal slices of the visible width
        bar      = (int'(h2) * 8) / int'(h_screen);
        ramp_sum = h2 + v2;
        case (mode2)
            pat_bars:     pix_exp = {{8{bar[2]}}, {8{bar[1]}}, {8{bar[0]}}};
            pat_ramp:     pix_exp = {ramp_sum[7:0], ramp_sum[7:0], ramp_sum[7:0]};
            pat_external: pix_exp = pix2;
            default:      pix_exp = '0;
        endcase

        sym[0] = tmds_red;
        sym[1] = tmds_green;
        sym[2] = tmds_blue;
        for (int c = 0; c < 3; c++) begin
            dec[c]     = tmds_decode(sym[c]);
            rd_now[c]  = rd[c] + sym_balance(sym[c]);
            bal_ok[c]  = (rd_now[c] <= 7'sd16) && (rd_now[c] >= -7'sd16);
            flag_ok[c] = flag_matches(sym[c]);
        end
    end

    // ------------------------------
    // History and running balance
    // ------------------------------
    always_ff @(posedge clk_pix) begin
        h1    <= hcount;
        h2    <= h1;
        v1    <= vcount;
        v2    <= v1;
        mode1 <= mode;
        mode2 <= mode1;
        pix1  <= pix;
        pix2  <= pix1;
        if (reset) begin
            run_cycles <= '0;
        end
        else if (run_cycles != 2'd3) begin
            run_cycles <= run_cycles + 2'd1;
        end
        // Balance restarts at every blanking gap
        for (int c = 0; c < 3; c++) begin
            rd[c] <= (checking && vis2) ? rd_now[c] : '0;
        end
    end

    // ------------------------------
    // Assertions
    // ------------------------------
    a_reset: assert property (@(posedge clk_pix) disable iff (reset)
        (run_cycles == 2'd0) |-> (hcount == '0) && (vcount == '0) &&
            (tmds_red == TMDS_CTRL_00) && (tmds_green == TMDS_CTRL_00) &&
            (tmds_blue == TMDS_CTRL_00))
        else begin
            err_count = err_count + 1;
            $error("Mismatch after reset hcount %h vcount %h red %h green %h blue %h",
                   $sampled(hcount), $sampled(vcount), $sampled(tmds_red),
                   $sampled(tmds_green), $sampled(tmds_blue));
        end

    a_count: assert property (@(posedge clk_pix) disable iff (reset)
        (run_cycles != 2'd0) |-> (hcount == h_exp) && (vcount == v_exp))
        else begin
            err_count = err_count + 1;
            $error("Mismatch hcount %h vcount %h expected %h %h",
                   $sampled(hcount), $sampled(vcount), $sampled(h_exp), $sampled(v_exp));
        end

    a_blank: assert property (@(posedge clk_pix) disable iff (reset)
        (checking && !vis2) |-> (tmds_red == TMDS_CTRL_00) &&
            (tmds_green == TMDS_CTRL_00) && (tmds_blue == blue_exp))
        else begin
            err_count = err_count + 1;
            $error("Mismatch blanking red %h green %h blue %h expected blue %h",
                   $sampled(tmds_red), $sampled(tmds_green), $sampled(tmds_blue),
                   $sampled(blue_exp));
        end

    a_pixel: assert property (@(posedge clk_pix) disable iff (reset)
        (checking && vis2) |-> ({dec[0], dec[1], dec[2]} == pix_exp))
        else begin
            err_count = err_count + 1;
            $error("Mismatch pixel got %h expected %h",
                   $sampled({dec[0], dec[1], dec[2]}), $sampled(pix_exp));
        end

    a_balance: assert property (@(posedge clk_pix) disable iff (reset)
        (checking && vis2) |-> (bal_ok == 3'b111) && (flag_ok == 3'b111))
        else begin
            err_count = err_count + 1;
            $error("DC balance out of range or XOR flag wrong on channels %b %b",
                   ~$sampled(bal_ok), ~$sampled(flag_ok));
        end

endmodule: hdmi_backend_chk

bind hdmi_backend hdmi_backend_chk #(
    .h_screen     (h_screen),
    .h_frame      (h_frame),
    .h_sync_start (h_sync_start),
    .h_sync_end   (h_sync_end),
    .v_screen     (v_screen),
    .v_frame      (v_frame),
    .v_sync_start (v_sync_start),
    .v_sync_end   (v_sync_end)
) u_chk (
    .clk_pix    (clk_pix),
    .reset      (reset),
    .mode       (mode),
    .pix        (pix),
    .hcount     (hcount),
    .vcount     (vcount),
    .tmds_red   (tmds_red),
    .tmds_green (tmds_green),
    .tmds_blue  (tmds_blue)
);

//--- hdmi_pixel_source.sv
/*
 * Pixel source
 * Colour bars, grey ramp or external pixel, one stage after the
 * timebase with all timing fields delayed to match
 */

`timescale 1ns/10ps

module hdmi_pixel_source #(
    parameter hdmi_pkg::bus11_t h_screen = 11'd32
) (
    input  logic               clk_pix,
    input  logic               reset,
    input  hdmi_pkg::pattern_t mode,
    input  hdmi_pkg::pix_t     pix,
    video_if.sink              vid_in,
    video_if.source            vid_out
);
    import hdmi_pkg::*;

    // Scaled position, hcount * 8 / h_screen
    logic [13:0] bar_pos;
    // Bar index, bit 2 red, bit 1 green, bit 0 blue
    logic [2:0]  bar;
    // Full sum of the position for the ramp
    bus11_t      ramp_sum;
    color_t      ramp;
    pix_t        pix_next;

    // ------------------------------
    // Pattern generation
    // ------------------------------
    always_comb begin
        // Eight equal bars over the visible width
        bar_pos  = {vid_in.hcount, 3'b000} / {3'b000, h_screen};
        bar      = bar_pos[2:0];

        // Diagonal grey ramp wraps every 256 steps
        ramp_sum = vid_in.hcount + vid_in.vcount;
        ramp     = ramp_sum[7:0];

        case (mode)
            pat_bars: begin
                pix_next = {{8{bar[2]}}, {8{bar[1]}}, {8{bar[0]}}};
            end
            pat_ramp: begin
                pix_next = {ramp, ramp, ramp};
            end
            pat_external: begin
                pix_next = pix;
            end
            default: begin
                pix_next = '0;
            end
        endcase
    end

    // ------------------------------
    // Output stage
    // ------------------------------
    always_ff @(posedge clk_pix) begin
        if (reset) begin
            vid_out.hcount <= '0;
            vid_out.vcount <= '0;
            vid_out.hsync  <= ~HSYNC_POLARITY;
            vid_out.vsync  <= ~VSYNC_POLARITY;
            // Empty pipeline shows as blanking to the encoders
            vid_out.blank  <= 1'b1;
        end
        else begin
            vid_out.hcount <= vid_in.hcount;
            vid_out.vcount <= vid_in.vcount;
            vid_out.hsync  <= vid_in.hsync;
            vid_out.vsync  <= vid_in.vsync;
            vid_out.blank  <= vid_in.blank;
        end
    end

    // Colour payload
    always_ff @(posedge clk_pix) begin
        vid_out.pix <= pix_next;
    end

endmodule: hdmi_pixel_source

//--- hdmi_pkg.sv
/*
 * HDMI back end shared definitions
 * Screen count, colour and symbol types, sync polarity,
 * pattern modes and the four TMDS control tokens
 */

package hdmi_pkg;

    // ------------------------------
    // Vector types
    // ------------------------------

    // Screen position, wide enough for 1280x720 frame totals
    typedef logic [10:0] bus11_t;

    // One colour component
    typedef logic [7:0]  color_t;

    // Packed pixel, red in the top byte and blue in the bottom byte
    typedef logic [23:0] pix_t;

    // Control pair of one TMDS channel
    // Blue carries vsync in bit 1 and hsync in bit 0
    typedef logic [1:0]  ctrl_t;

    // One 10-bit TMDS symbol, bit 0 goes out first on the wire
    typedef logic [9:0]  symbol_t;

    // ------------------------------
    // Pixel source modes
    // ------------------------------

    // Encoding 2'b11 is unused and produces black
    typedef enum logic [1:0] {
        pat_bars     = 2'd0,
        pat_ramp     = 2'd1,
        pat_external = 2'd2
    } pattern_t;

    // ------------------------------
    // Sync polarity
    // ------------------------------

    // Active level of each sync
    // With active-high syncs the idle control pair is 2'b00
    localparam logic HSYNC_POLARITY = 1'b1;
    localparam logic VSYNC_POLARITY = 1'b1;

    // ------------------------------
    // TMDS control tokens
    // ------------------------------

    // Indexed by the control pair {c1, c0}
    // Sent during blanking in place of pixel data
    localparam symbol_t TMDS_CTRL_00 = 10'b1101010100;
    localparam symbol_t TMDS_CTRL_01 = 10'b0010101011;
    localparam symbol_t TMDS_CTRL_10 = 10'b0101010100;
    localparam symbol_t TMDS_CTRL_11 = 10'b1010101011;

endpackage: hdmi_pkg

//--- hdmi_tdms_enc.sv
/*
 * TMDS encoder, one channel
 * Transition-minimised, DC-balanced 8b/10b symbols for visible
 * pixels and control tokens during blanking
 */

`timescale 1ns/10ps

module hdmi_tdms_enc (
    input  logic              clk_pix,
    input  logic              reset,
    input  logic              blank,
    input  hdmi_pkg::ctrl_t   ctrl,
    input  hdmi_pkg::color_t  data,
    output hdmi_pkg::symbol_t encoded
);
    import hdmi_pkg::*;

    // Stage 1 results
    logic [3:0]        ones_data;
    logic              use_xnor;
    logic [8:0]        q_m;

    // Stage 2 results
    logic [3:0]        ones_qm;
    // Ones minus zeros of q_m[7:0], range -8 to 8
    logic signed [5:0] bal_qm;
    // Running disparity, ones minus zeros sent so far
    logic signed [5:0] disp;
    logic signed [5:0] disp_next;
    symbol_t           data_sym;
    symbol_t           ctrl_sym;

    // ------------------------------
    // Transition minimisation
    // ------------------------------
    always_comb begin
        ones_data = '0;
        for (int i = 0; i < 8; i++) begin
            ones_data = ones_data + 4'(data[i]);
        end

        // XNOR when the byte is mostly ones, ties broken by bit 0
        use_xnor = (ones_data > 4'd4) || ((ones_data == 4'd4) && !data[0]);

        q_m[0] = data[0];
        for (int i = 1; i < 8; i++) begin
            if (use_xnor) begin
                q_m[i] = ~(q_m[i-1] ^ data[i]);
            end
            else begin
                q_m[i] = q_m[i-1] ^ data[i];
            end
        end
        // Flag for the decoder, set for XOR
        q_m[8] = ~use_xnor;
    end

    // ------------------------------
    // DC balance
    // ------------------------------
    always_comb begin
        ones_qm = '0;
        for (int i = 0; i < 8; i++) begin
            ones_qm = ones_qm + 4'(q_m[i]);
        end
        bal_qm = $signed({1'b0, ones_qm, 1'b0}) - 6'sd8;

        if ((disp == 6'sd0) || (bal_qm == 6'sd0)) begin
            // Neutral case, bit 9 mirrors bit 8
            data_sym = {~q_m[8], q_m[8], (q_m[8] ? q_m[7:0] : ~q_m[7:0])};
            if (q_m[8]) begin
                disp_next = disp + bal_qm;
            end
            else begin
                disp_next = disp - bal_qm;
            end
        end
        else if (((disp > 6'sd0) && (bal_qm > 6'sd0)) ||
                 ((disp < 6'sd0) && (bal_qm < 6'sd0))) begin
            // Same sign as the running total, so invert the byte
            data_sym  = {1'b1, q_m[8], ~q_m[7:0]};
            disp_next = disp + (q_m[8] ? 6'sd2 : 6'sd0) - bal_qm;
        end
        else begin
            data_sym  = {1'b0, q_m[8], q_m[7:0]};
            disp_next = disp - (q_m[8] ? 6'sd0 : 6'sd2) + bal_qm;
        end
    end

    // Control token during blanking
    always_comb begin
        case (ctrl)
            2'b00:   ctrl_sym = TMDS_CTRL_00;
            2'b01:   ctrl_sym = TMDS_CTRL_01;
            2'b10:   ctrl_sym = TMDS_CTRL_10;
            default: ctrl_sym = TMDS_CTRL_11;
        endcase
    end

    // ------------------------------
    // Symbol register
    // ------------------------------
    always_ff @(posedge clk_pix) begin
        if (reset) begin
            encoded <= TMDS_CTRL_00;
            disp    <= '0;
        end
        else if (blank) begin
            // Each active line starts from a neutral balance
            encoded <= ctrl_sym;
            disp    <= '0;
        end
        else begin
            encoded <= data_sym;
            disp    <= disp_next;
        end
    end

endmodule: hdmi_tdms_enc

//--- hdmi_timebase.sv
/*
 * Screen timebase
 * Horizontal and vertical counters with registered sync and blank,
 * all aligned on the same stage
 */

`timescale 1ns/10ps

module hdmi_timebase #(
    parameter hdmi_pkg::bus11_t h_screen     = 11'd32,
    parameter hdmi_pkg::bus11_t h_frame      = 11'd44,
    parameter hdmi_pkg::bus11_t h_sync_start = 11'd35,
    parameter hdmi_pkg::bus11_t h_sync_end   = 11'd39,
    parameter hdmi_pkg::bus11_t v_screen     = 11'd8,
    parameter hdmi_pkg::bus11_t v_frame      = 11'd12,
    parameter hdmi_pkg::bus11_t v_sync_start = 11'd9,
    parameter hdmi_pkg::bus11_t v_sync_end   = 11'd10
) (
    input  logic    clk_pix,
    input  logic    reset,
    video_if.source vid
);
    import hdmi_pkg::*;

    // Next position of the scan
    bus11_t hcount_next;
    bus11_t vcount_next;

    // ------------------------------
    // Next count
    // ------------------------------
    always_comb begin
        hcount_next = vid.hcount + 11'd1;
        vcount_next = vid.vcount;

        // Line wrap steps the row, frame wrap returns to the top
        if (vid.hcount == h_frame - 11'd1) begin
            hcount_next = '0;
            if (vid.vcount == v_frame - 11'd1) begin
                vcount_next = '0;
            end
            else begin
                vcount_next = vid.vcount + 11'd1;
            end
        end
    end

    // ------------------------------
    // Counters, sync and blank
    // ------------------------------
    // Sync and blank come from the next count so that they
    // land on the same edge as the position they belong to
    always_ff @(posedge clk_pix) begin
        if (reset) begin
            vid.hcount <= '0;
            vid.vcount <= '0;
            vid.hsync  <= ~HSYNC_POLARITY;
            vid.vsync  <= ~VSYNC_POLARITY;
            // Position 0,0 is visible
            vid.blank  <= 1'b0;
        end
        else begin
            vid.hcount <= hcount_next;
            vid.vcount <= vcount_next;

            if ((hcount_next >= h_sync_start) && (hcount_next < h_sync_end)) begin
                vid.hsync <= HSYNC_POLARITY;
            end
            else begin
                vid.hsync <= ~HSYNC_POLARITY;
            end

            if ((vcount_next >= v_sync_start) && (vcount_next < v_sync_end)) begin
                vid.vsync <= VSYNC_POLARITY;
            end
            else begin
                vid.vsync <= ~VSYNC_POLARITY;
            end

            vid.blank <= (hcount_next >= h_screen) || (vcount_next >= v_screen);
        end
    end

    // No colour is produced at this stage
    assign vid.pix = '0;

endmodule: hdmi_timebase

//--- run_sim.sh
#!/bin/sh
# Build and run the HDMI back end testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -f hdmi_backend.f --top-module tb_hdmi_backend \
    -o tb_hdmi_backend \
    && ./obj_dir/tb_hdmi_backend +verilator+error+limit+1000 > sim.log 2>&1 \
    || { echo "Build or simulation failed, see sim.log"; exit 1; }

grep -q "^Done: no errors$" sim.log \
    && echo "PASS" \
    || { echo "FAIL, see sim.log"; exit 1; }

//--- tb_hdmi_backend.sv
/*
 * Testbench for the HDMI back end
 * Reset, colour bars, grey ramp and external pixel runs, checked
 * by the bound assertion module
 */

`timescale 1ns/10ps

module tb_hdmi_backend;
    import hdmi_pkg::*;

    // Default frame of the DUT
    localparam int H_FRAME         = 44;
    localparam int V_FRAME         = 12;
    localparam int FRAME_CYCLES    = H_FRAME * V_FRAME;
    localparam int FRAMES_PER_TEST = 3;
    // Three pattern runs plus two spare frames, slack for four resets
    localparam int TIMEOUT_CYCLES  = (3 * FRAMES_PER_TEST + 2) * FRAME_CYCLES + 192;

    logic     clk_pix = 1'b0;
    logic     reset;
    pattern_t mode;
    pix_t     pix;
    bus11_t   hcount;
    bus11_t   vcount;
    symbol_t  tmds_red;
    symbol_t  tmds_green;
    symbol_t  tmds_blue;

    int       seed;
    int       cycle_count = 0;
    int       test_count;
    int       errors_before;
    int       total_errors;

    // ------------------------------
    // Clock, DUT and timeout
    // ------------------------------
    always #50 clk_pix = ~clk_pix;

    hdmi_backend u_dut (
        .clk_pix    (clk_pix),
        .reset      (reset),
        .mode       (mode),
        .pix        (pix),
        .hcount     (hcount),
        .vcount     (vcount),
        .tmds_red   (tmds_red),
        .tmds_green (tmds_green),
        .tmds_blue  (tmds_blue)
    );

    always @(posedge clk_pix) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Tests run: %0d, errors: %0d", test_count, u_dut.u_chk.err_count + 1);
            $display("Done: errors found");
            $finish;
        end
    end

    // ------------------------------
    // Tasks
    // ------------------------------
    // Reset for five clocks, released on a falling edge
    task automatic apply_reset();
        @(negedge clk_pix);
        reset = 1'b1;
        pix   = '0;
        repeat (5) @(negedge clk_pix);
        reset = 1'b0;
    endtask

    // Whole frames in one mode, frame starts seen on the scan outputs
    task automatic run_pattern(input pattern_t run_mode, input logic random_pix);
        int starts;
        int rnd;
        starts = 0;
        mode   = run_mode;
        apply_reset();
        while (starts < FRAMES_PER_TEST) begin
            @(negedge clk_pix);
            if (random_pix) begin
                rnd = $random(seed);
                pix = rnd[23:0];
            end
            if ((hcount == '0) && (vcount == '0)) begin
                starts = starts + 1;
            end
        end
    endtask

    // One line per finished test with the assertions failed during it
    task automatic report_test(input string name);
        int errs;
        errs          = u_dut.u_chk.err_count - errors_before;
        test_count    = test_count + 1;
        errors_before = u_dut.u_chk.err_count;
        $display("Test %0d %s finished with %0d errors", test_count, name, errs);
    endtask

    // ------------------------------
    // Test sequence
    // ------------------------------
    initial begin
        reset         = 1'b1;
        mode          = pat_bars;
        pix           = '0;
        seed          = 32'hf967_9bcb;
        test_count    = 0;
        errors_before = 0;

        // Symbols need two clocks to follow the reset release
        apply_reset();
        repeat (4) @(negedge clk_pix);
        report_test("reset check");

        run_pattern(pat_bars, 1'b0);
        report_test("colour bars");

        run_pattern(pat_ramp, 1'b0);
        report_test("grey ramp");

        run_pattern(pat_external, 1'b1);
        repeat (3) @(negedge clk_pix);
        report_test("external pixels");

        total_errors = u_dut.u_chk.err_count;
        $display("Tests run: %0d, errors: %0d", test_count, total_errors);
        if (total_errors == 0) begin
            $display("Done: no errors");
        end
        else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule: tb_hdmi_backend

//--- video_if.sv
/*
 * Video stage bus
 * Screen position, sync, blank and pixel moving one item per clock
 */

`timescale 1ns/10ps

interface video_if;
    import hdmi_pkg::*;

    // Screen position of the item in this stage
    bus11_t hcount;
    bus11_t vcount;

    // Sync levels, already at the polarity of the display mode
    logic   hsync;
    logic   vsync;

    // High outside the visible area
    logic   blank;

    // Pixel colour, left at zero by the timebase
    pix_t   pix;

    // Producer side of a stage
    modport source (
        output hcount,
        output vcount,
        output hsync,
        output vsync,
        output blank,
        output pix
    );

    // Consumer side of a stage
    modport sink (
        input hcount,
        input vcount,
        input hsync,
        input vsync,
        input blank,
        input pix
    );

endinterface: video_if
